// File: logic/obj_pkg.sv
// Shared types and constants for the sprite engine
// Imported by the drawer, scanner, line buffer and top level
package obj_pkg;

    // Sprite size in pixels, both directions
    localparam int OBJ_H = 16;

    // Visible pixels per line
    localparam int LINE_W = 256;

    // Byte offsets inside one four-byte table entry
    localparam logic [1:0] OFS_Y    = 2'd0;
    localparam logic [1:0] OFS_CODE = 2'd1;
    localparam logic [1:0] OFS_ATTR = 2'd2;
    localparam logic [1:0] OFS_X    = 2'd3;

    // 4-bit colour, 0 is transparent
    typedef logic [3:0] pxl_t;

    // Attribute byte as stored in the table
    typedef struct packed {
        logic       vflip;
        logic       hflip;
        logic [1:0] spare;
        logic [3:0] pal;
    } attr_t;

    // Graphics ROM word address
    // Half selects sprite columns 0-7 or 8-15
    typedef struct packed {
        logic [7:0] code;
        logic [3:0] row;
        logic       half;
    } rom_addr_t;

endpackage

// File: logic/obj_tbl_if.sv
// Scanner read port into the shared object table
// Request is held until grant; read data follows one cycle after grant
`timescale 1ns/100ps

interface obj_tbl_if #(
    parameter int AW = 7
);
    logic          req;
    logic [AW-1:0] addr;
    logic          gnt;
    logic [7:0]    rdata;

    modport arb (
        input  req, addr,
        output gnt, rdata
    );

    modport scan (
        output req, addr,
        input  gnt, rdata
    );
endinterface

// File: logic/obj_req_if.sv
// Draw request from the table scanner to the sprite drawer
// start is a single-cycle strobe, only issued while busy is low
`timescale 1ns/100ps

interface obj_req_if;
    logic       start;
    logic [7:0] code;
    logic [7:0] xpos;
    logic [3:0] pal;
    logic       hflip;
    logic       vflip;
    logic [3:0] ysub;
    logic       busy;

    modport scan (
        output start, code, xpos, pal, hflip, vflip, ysub,
        input  busy
    );

    modport draw (
        input  start, code, xpos, pal, hflip, vflip, ysub,
        output busy
    );
endinterface

// File: logic/obj_tbl_arbiter.sv
// Object table RAM shared by the CPU and the scanner
// CPU always wins; scanner is granted in idle CPU cycles
`timescale 1ns/100ps

module obj_tbl_arbiter #(
    parameter int NUM_OBJ = 32,
    parameter int ADDR_W  = 7
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic [7:0]        cpu_din,
    input  logic              cpu_we,
    input  logic              cpu_rd,
    output logic [7:0]        cpu_dout,
    obj_tbl_if.arb            tbl
);

    // Four bytes per object
    logic [7:0]        mem [NUM_OBJ*4];
    logic              cpu_act;
    logic [ADDR_W-1:0] ram_addr;
    logic [7:0]        ram_q;
    logic              rd_pend;
    logic [7:0]        dout_hold;

    assign cpu_act  = cpu_we | cpu_rd;
    // Single port, CPU address takes over
    assign ram_addr = cpu_act ? cpu_addr : tbl.addr;
    assign tbl.gnt  = tbl.req & ~cpu_act;

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
        ram_q <= mem[ram_addr];
    end

    // RAM output serves the scanner after a grant
    assign tbl.rdata = ram_q;

    // Flags the cycle where RAM output belongs to the CPU
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= cpu_rd;
        end
    end

    // Last CPU read stays on the bus until the next one
    assign cpu_dout = rd_pend ? ram_q : dout_hold;

    always_ff @(posedge clk) begin
        dout_hold <= cpu_dout;
    end

    // CPU strobes are exclusive
    a_cpu_excl: assert property (
        @(posedge clk) disable iff (rst) !(cpu_we && cpu_rd)
    );

    // Scanner keeps its request steady while the CPU holds the RAM
    a_req_hold: assert property (
        @(posedge clk) disable iff (rst)
        tbl.req && !tbl.gnt |=> tbl.req && $stable(tbl.addr)
    );

endmodule

// File: logic/obj_scan.sv
// Per-line walk of the object table, highest index first
// Issues one draw request for each object that covers vrender
`timescale 1ns/100ps

module obj_scan #(
    parameter int NUM_OBJ = 32,
    parameter int ADDR_W  = 7
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       hinit,
    input  logic [7:0] vrender,
    obj_tbl_if.scan    tbl,
    obj_req_if.scan    req
);
    import obj_pkg::*;

    localparam int IW = ADDR_W - 2;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_DATA,
        S_ISSUE
    } state_t;

    state_t        st;
    logic [IW-1:0] idx;
    logic [1:0]    ofs;
    logic [7:0]    ydiff;
    attr_t         rd_attr;
    logic          last;

    // Row inside the sprite, out of zone when 16 or more
    assign ydiff   = vrender - tbl.rdata;
    assign rd_attr = tbl.rdata;
    assign last    = (idx == '0);

    assign tbl.req  = (st == S_REQ);
    assign tbl.addr = {idx, ofs};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            st        <= S_IDLE;
            idx       <= '0;
            ofs       <= OFS_Y;
            req.start <= 1'b0;
        end else begin
            req.start <= 1'b0;
            case (st)
                S_IDLE: if (hinit) begin
                    idx <= IW'(NUM_OBJ - 1);
                    ofs <= OFS_Y;
                    st  <= S_REQ;
                end
                S_REQ: if (tbl.gnt) begin
                    st <= S_DATA;
                end
                S_DATA: begin
                    ofs <= ofs + 2'd1;
                    st  <= S_REQ;
                    // Skip the rest of the entry when out of zone
                    if (ofs == OFS_Y && ydiff[7:4] != 4'd0) begin
                        ofs <= OFS_Y;
                        idx <= idx - 1'b1;
                        if (last) st <= S_IDLE;
                    end
                    if (ofs == OFS_X) begin
                        st <= S_ISSUE;
                    end
                end
                S_ISSUE: if (!req.busy) begin
                    req.start <= 1'b1;
                    ofs       <= OFS_Y;
                    idx       <= idx - 1'b1;
                    st        <= last ? S_IDLE : S_REQ;
                end
                default: st <= S_IDLE;
            endcase
        end
    end

    // Entry bytes land straight in the request fields
    always_ff @(posedge clk) begin
        if (st == S_DATA) begin
            case (ofs)
                OFS_Y:    req.ysub <= ydiff[3:0];
                OFS_CODE: req.code <= tbl.rdata;
                OFS_ATTR: begin
                    req.pal   <= rd_attr.pal;
                    req.hflip <= rd_attr.hflip;
                    req.vflip <= rd_attr.vflip;
                end
                default:  req.xpos <= tbl.rdata;
            endcase
        end
    end

    // Whole table must be done within one line
    a_scan_done: assert property (
        @(posedge clk) disable iff (rst) hinit |-> st == S_IDLE
    );

endmodule

// File: logic/obj_draw.sv
// Fetches one 16-pixel sprite row from graphics ROM
// and writes its opaque pixels into the line buffer
`timescale 1ns/100ps

module obj_draw (
    input  logic              clk,
    input  logic              rst,
    obj_req_if.draw           req,
    output logic              rom_cs,
    output obj_pkg::rom_addr_t rom_addr,
    input  logic [31:0]       rom_data,
    input  logic              rom_ok,
    output logic              wr_en,
    output logic [7:0]        wr_addr,
    output obj_pkg::pxl_t     wr_data
);
    import obj_pkg::*;

    localparam int CW = $clog2(OBJ_H);

    typedef enum logic [1:0] {
        D_IDLE,
        D_FETCH,
        D_GAP,
        D_WRITE
    } dstate_t;

    dstate_t          st;
    logic             half;
    logic [CW-1:0]    col;
    logic [CW-1:0]    scol;
    logic [7:0]       code;
    logic [7:0]       xpos;
    logic [3:0]       row;
    logic [3:0]       pal;
    logic             hflip;
    logic [OBJ_H*4-1:0] pix_row;
    pxl_t             nib;
    logic [8:0]       scr;

    assign rom_addr = '{code: code, row: row, half: half};

    // Sprite column shown at screen offset col
    assign scol = col ^ {CW{hflip}};
    // Low nibble of half 0 is column 0
    assign nib  = pix_row[{scol, 2'b00} +: 4];
    assign scr  = {1'b0, xpos} + 9'(col);

    // Transparent and off-screen columns are skipped
    assign wr_en   = (st == D_WRITE) && (nib != 4'd0) && !scr[8];
    assign wr_addr = scr[7:0];
    assign wr_data = nib ^ pal;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            st       <= D_IDLE;
            rom_cs   <= 1'b0;
            req.busy <= 1'b0;
            half     <= 1'b0;
            col      <= '0;
        end else begin
            case (st)
                D_IDLE: if (req.start) begin
                    req.busy <= 1'b1;
                    half     <= 1'b0;
                    rom_cs   <= 1'b1;
                    st       <= D_FETCH;
                end
                D_FETCH: if (rom_ok) begin
                    rom_cs <= 1'b0;
                    col    <= '0;
                    st     <= half ? D_WRITE : D_GAP;
                end
                // One idle cycle between the two ROM requests
                D_GAP: begin
                    half   <= 1'b1;
                    rom_cs <= 1'b1;
                    st     <= D_FETCH;
                end
                D_WRITE: begin
                    col <= col + 1'b1;
                    if (col == CW'(OBJ_H - 1)) begin
                        req.busy <= 1'b0;
                        st       <= D_IDLE;
                    end
                end
                default: st <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == D_IDLE && req.start) begin
            code  <= req.code;
            xpos  <= req.xpos;
            pal   <= req.pal;
            hflip <= req.hflip;
            // Vertical flip picks the mirrored row
            row   <= req.ysub ^ {4{req.vflip}};
        end
        if (st == D_FETCH && rom_ok) begin
            if (half) begin
                pix_row[OBJ_H*4-1:OBJ_H*2] <= rom_data;
            end else begin
                pix_row[OBJ_H*2-1:0] <= rom_data;
            end
        end
    end

    // ROM request must not move before it is served
    a_rom_stable: assert property (
        @(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr)
    );

endmodule

// File: logic/obj_linebuf.sv
// Double line buffer, one half filled while the other is shown
// Halves swap on hinit; shown pixels are cleared behind the read
`timescale 1ns/100ps

module obj_linebuf (
    input  logic          clk,
    input  logic          rst,
    input  logic          hinit,
    input  logic          wr_en,
    input  logic [7:0]    wr_addr,
    input  obj_pkg::pxl_t wr_data,
    input  logic          pxl_cen,
    input  logic [7:0]    hdump,
    output obj_pkg::pxl_t pxl
);
    import obj_pkg::*;

    // Half currently being filled
    logic sel;
    pxl_t rd_pix [2];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sel <= 1'b0;
        end else if (hinit) begin
            sel <= ~sel;
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_half
        pxl_t              mem [LINE_W];
        // Column holds a pixel written since its last read
        logic [LINE_W-1:0] vld;
        logic              fill;

        assign fill = (sel == 1'(b));

        always_ff @(posedge clk) begin
            if (wr_en && fill) begin
                mem[wr_addr] <= wr_data;
            end
        end

        always_ff @(posedge clk, posedge rst) begin
            if (rst) begin
                vld <= '0;
            end else begin
                if (wr_en && fill) vld[wr_addr] <= 1'b1;
                // Clear after read on the display side
                if (pxl_cen && !fill) vld[hdump] <= 1'b0;
            end
        end

        assign rd_pix[b] = vld[hdump] ? mem[hdump] : '0;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= rd_pix[~sel];
        end
    end

endmodule

// File: logic/obj_engine.sv
// Sprite engine top level: table RAM, scanner, drawer and line buffer
// CPU writes the table; pixels come out one line after being built
`timescale 1ns/100ps

module obj_engine #(
    parameter int NUM_OBJ = 32,
    parameter int ADDR_W  = $clog2(NUM_OBJ) + 2
) (
    input  logic               clk,
    input  logic               rst,
    // CPU port
    input  logic [ADDR_W-1:0]  cpu_addr,
    input  logic [7:0]         cpu_din,
    input  logic               cpu_we,
    input  logic               cpu_rd,
    output logic [7:0]         cpu_dout,
    // Video timing
    input  logic               hinit,
    input  logic [7:0]         vrender,
    input  logic               pxl_cen,
    input  logic [7:0]         hdump,
    output obj_pkg::pxl_t      pxl,
    // Graphics ROM
    output logic               rom_cs,
    output obj_pkg::rom_addr_t rom_addr,
    input  logic [31:0]        rom_data,
    input  logic               rom_ok
);
    import obj_pkg::*;

    // Drawer to line buffer
    logic       wr_en;
    logic [7:0] wr_addr;
    pxl_t       wr_data;

    obj_tbl_if #(.AW(ADDR_W)) tbl_bus ();
    obj_req_if                req_bus ();

    obj_tbl_arbiter #(
        .NUM_OBJ  ( NUM_OBJ  ),
        .ADDR_W   ( ADDR_W   )
    ) u_arb (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cpu_addr ( cpu_addr ),
        .cpu_din  ( cpu_din  ),
        .cpu_we   ( cpu_we   ),
        .cpu_rd   ( cpu_rd   ),
        .cpu_dout ( cpu_dout ),
        .tbl      ( tbl_bus  )
    );

    obj_scan #(
        .NUM_OBJ  ( NUM_OBJ  ),
        .ADDR_W   ( ADDR_W   )
    ) u_scan (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .hinit    ( hinit    ),
        .vrender  ( vrender  ),
        .tbl      ( tbl_bus  ),
        .req      ( req_bus  )
    );

    obj_draw u_draw (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .req      ( req_bus  ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .wr_en    ( wr_en    ),
        .wr_addr  ( wr_addr  ),
        .wr_data  ( wr_data  )
    );

    obj_linebuf u_lbuf (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .hinit    ( hinit    ),
        .wr_en    ( wr_en    ),
        .wr_addr  ( wr_addr  ),
        .wr_data  ( wr_data  ),
        .pxl_cen  ( pxl_cen  ),
        .hdump    ( hdump    ),
        .pxl      ( pxl      )
    );

endmodule

// File: tests/gfx_rom_model.sv
// Graphics ROM model for the sprite engine testbench
// Word content comes from the address; each request answers after 1 to 8 clocks
`timescale 1ns/100ps

module gfx_rom_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        cs,
    input  logic [12:0] addr,
    output logic [31:0] data,
    output logic        ok
);

    integer      seed;
    logic        busy;
    logic [2:0]  wait_cnt;
    logic [31:0] r;

    initial seed = 80512;

    // Nibble k is the folded address plus k
    function automatic logic [31:0] word_at(input logic [12:0] a);
        logic [31:0] w;
        logic [3:0]  base;
        base = a[3:0] ^ a[7:4] ^ a[11:8] ^ {3'b000, a[12]};
        for (int k = 0; k < 8; k++) begin
            w[k*4 +: 4] = base + 4'(k);
        end
        return w;
    endfunction

    // Falling edge, so the drawer sees ok and data settled
    always @(negedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            ok       <= 1'b0;
            wait_cnt <= '0;
            data     <= '0;
        end else begin
            ok <= 1'b0;
            // cs drops on the edge that takes the word
            if (!ok) begin
                if (busy) begin
                    if (wait_cnt == 3'd0) begin
                        busy <= 1'b0;
                        ok   <= 1'b1;
                        data <= word_at(addr);
                    end else begin
                        wait_cnt <= wait_cnt - 3'd1;
                    end
                end else if (cs) begin
                    r = $random(seed);
                    busy     <= 1'b1;
                    wait_cnt <= r[2:0];
                end
            end
        end
    end

endmodule

// File: tests/obj_engine_tb.sv
// Testbench for the sprite engine
// Loads object tables over the CPU port, runs video lines and checks
// every shown pixel against a reference renderer
`timescale 1ns/100ps

module obj_engine_tb;
    import obj_pkg::*;

    localparam int NUM_OBJ  = 32;
    localparam int ADDR_W   = $clog2(NUM_OBJ) + 2;
    localparam int LINE_CLK = 1536;
    localparam int IDLE_TO  = 2000;

    typedef pxl_t line_t [LINE_W];

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] cpu_addr;
    logic [7:0]        cpu_din;
    logic              cpu_we;
    logic              cpu_rd;
    logic [7:0]        cpu_dout;
    logic              hinit;
    logic [7:0]        vrender;
    logic              pxl_cen;
    logic [7:0]        hdump;
    pxl_t              pxl;
    logic              rom_cs;
    rom_addr_t         rom_addr;
    logic [31:0]       rom_data;
    logic              rom_ok;

    // Table copy plus the expected line being built and the line on show
    logic [7:0] tbl_copy [NUM_OBJ*4];
    line_t      exp_built;
    line_t      exp_show;
    logic       chk_on;
    logic       rom_quiet;
    logic       cen_s;
    logic [7:0] col_s;
    integer     seed;

    obj_engine #(.NUM_OBJ(NUM_OBJ)) uut (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cpu_addr ( cpu_addr ),
        .cpu_din  ( cpu_din  ),
        .cpu_we   ( cpu_we   ),
        .cpu_rd   ( cpu_rd   ),
        .cpu_dout ( cpu_dout ),
        .hinit    ( hinit    ),
        .vrender  ( vrender  ),
        .pxl_cen  ( pxl_cen  ),
        .hdump    ( hdump    ),
        .pxl      ( pxl      ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   )
    );

    gfx_rom_model rom (
        .clk  ( clk      ),
        .rst  ( rst      ),
        .cs   ( rom_cs   ),
        .addr ( rom_addr ),
        .data ( rom_data ),
        .ok   ( rom_ok   )
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // ROM nibble from the folded address plus the nibble index
    function automatic pxl_t rom_nib(input logic [12:0] a, input int k);
        int f;
        f = a[3:0] ^ a[7:4] ^ a[11:8] ^ a[12];
        return pxl_t'((f + k) % 16);
    endfunction

    // Expected line for vrender v from the table copy
    function automatic line_t render_line(input logic [7:0] v);
        line_t      ln;
        logic [7:0] ysub;
        attr_t      at;
        logic [3:0] row;
        int         sc;
        int         scr;
        pxl_t       n;
        for (int c = 0; c < LINE_W; c++) ln[c] = '0;
        // Highest index first so index 0 ends on top
        for (int i = NUM_OBJ - 1; i >= 0; i--) begin
            ysub = v - tbl_copy[i*4 + OFS_Y];
            at   = tbl_copy[i*4 + OFS_ATTR];
            if (ysub < 8'd16) begin
                row = at.vflip ? 4'd15 - ysub[3:0] : ysub[3:0];
                for (int c = 0; c < OBJ_H; c++) begin
                    sc  = at.hflip ? OBJ_H - 1 - c : c;
                    scr = tbl_copy[i*4 + OFS_X] + c;
                    n   = rom_nib({tbl_copy[i*4 + OFS_CODE], row, sc >= 8}, sc % 8);
                    // Transparent and clipped columns leave the line alone
                    if (n != 0 && scr < LINE_W) ln[scr] = n ^ at.pal;
                end
            end
        end
        return ln;
    endfunction

    task automatic cpu_write(input int a, input logic [7:0] d);
        @(negedge clk);
        cpu_addr    = ADDR_W'(a);
        cpu_din     = d;
        cpu_we      = 1'b1;
        tbl_copy[a] = d;
        @(negedge clk);
        cpu_we = 1'b0;
    endtask

    // Read data arrives one clock after the strobe
    task automatic cpu_read_check(input int a);
        @(negedge clk);
        cpu_addr = ADDR_W'(a);
        cpu_rd   = 1'b1;
        @(negedge clk);
        cpu_rd = 1'b0;
        assert (cpu_dout === tbl_copy[a]) else
            stop_run($sformatf("** Error at %0d ns: table byte %0d reads %h, expected %h",
                $time, a, cpu_dout, tbl_copy[a]));
    endtask

    task automatic put_obj(input int i, input logic [7:0] y, input logic [7:0] code,
                           input logic [7:0] attr, input logic [7:0] x);
        cpu_write(i*4 + OFS_Y, y);
        cpu_write(i*4 + OFS_CODE, code);
        cpu_write(i*4 + OFS_ATTR, attr);
        cpu_write(i*4 + OFS_X, x);
    endtask

    // Y far below any line used keeps every object out of zone
    task automatic clear_table();
        for (int i = 0; i < NUM_OBJ; i++) put_obj(i, 8'hF0, 8'h00, 8'h00, 8'h00);
    endtask

    task automatic random_table(input logic [7:0] v);
        logic [31:0] r;
        for (int i = 0; i < NUM_OBJ; i++) begin
            r = $random(seed);
            // Y up to 31 lines above v puts about half in zone
            put_obj(i, v - {3'b000, r[4:0]}, r[15:8], r[23:16], r[31:24]);
        end
    endtask

    // Four quiet clocks in a row with no table request and an idle drawer
    task automatic wait_idle();
        int quiet;
        int t;
        quiet = 0;
        t     = 0;
        while (quiet < 4) begin
            @(negedge clk);
            quiet = (uut.tbl_bus.req || uut.req_bus.busy) ? 0 : quiet + 1;
            t++;
            if (t > IDLE_TO) stop_run("Timeout: sprite scan did not return to idle");
        end
    endtask

    // One video line with hinit first and a pixel every fourth clock
    task automatic run_line(input logic [7:0] v);
        exp_show  = exp_built;
        exp_built = render_line(v);
        @(negedge clk);
        for (int n = 0; n < LINE_CLK; n++) begin
            vrender = v;
            hinit   = (n == 0);
            pxl_cen = (n >= 4) && (n % 4 == 0) && (n <= 4 * LINE_W);
            if (pxl_cen) hdump = 8'((n - 4) / 4);
            @(negedge clk);
        end
        hinit   = 1'b0;
        pxl_cen = 1'b0;
        wait_idle();
    endtask

    // CPU strobes in the middle of a scan touch spare attribute bits only
    task automatic cpu_traffic();
        logic [31:0] r;
        int          a;
        repeat (3) @(negedge clk);
        for (int k = 0; k < 24; k++) begin
            r = $random(seed);
            a = (int'(r[7:0]) % NUM_OBJ) * 4 + OFS_ATTR;
            cpu_write(a, (tbl_copy[a] & 8'hCF) | (r[15:8] & 8'h30));
            repeat (int'(r[17:16])) @(negedge clk);
            cpu_read_check(a);
            cpu_read_check(int'(r[30:24]) % (NUM_OBJ * 4));
        end
    endtask

    always @(posedge clk) begin
        cen_s <= pxl_cen;
        col_s <= hdump;
    end

    // Pixel of a pxl_cen cycle is checked one clock later
    always @(negedge clk) begin
        if (chk_on && cen_s) begin
            assert (pxl === exp_show[col_s]) else
                stop_run($sformatf("** Error at %0d ns: column %0d shows %h, expected %h",
                    $time, col_s, pxl, exp_show[col_s]));
        end
        if (rom_quiet) begin
            assert (rom_cs === 1'b0) else
                stop_run($sformatf("** Error at %0d ns: rom_cs high with an empty table",
                    $time));
        end
    end

    initial begin
        logic [31:0] r;
        logic [7:0]  v;
        seed      = 80512;
        rst       = 1'b1;
        cpu_addr  = '0;
        cpu_din   = '0;
        cpu_we    = 1'b0;
        cpu_rd    = 1'b0;
        hinit     = 1'b0;
        vrender   = '0;
        pxl_cen   = 1'b0;
        hdump     = '0;
        chk_on    = 1'b0;
        rom_quiet = 1'b0;
        for (int c = 0; c < LINE_W; c++) exp_built[c] = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // Empty table gives no fetch and a blank line
        clear_table();
        chk_on    = 1'b1;
        rom_quiet = 1'b1;
        run_line(8'd100);
        run_line(8'd100);
        rom_quiet = 1'b0;

        // Plain sprite followed by blank lines from the cleared half
        put_obj(3, 8'd40, 8'h5A, 8'h07, 8'd30);
        run_line(8'd45);
        run_line(8'd200);
        run_line(8'd200);
        run_line(8'd200);

        // hflip, vflip and both on one line
        clear_table();
        put_obj(0, 8'd60, 8'h11, 8'h42, 8'd20);
        put_obj(1, 8'd58, 8'h22, 8'h83, 8'd60);
        put_obj(2, 8'd55, 8'h33, 8'hC9, 8'd100);
        run_line(8'd63);

        // Overlap decided by index and clipping at the right edge
        clear_table();
        put_obj(5, 8'd120, 8'h40, 8'h01, 8'd70);
        put_obj(2, 8'd118, 8'h41, 8'h0C, 8'd76);
        put_obj(9, 8'd121, 8'h42, 8'h05, 8'd250);
        run_line(8'd125);

        random_table(8'd80);
        fork
            run_line(8'd80);
            cpu_traffic();
        join

        for (int l = 0; l < 20; l++) begin
            r = $random(seed);
            v = r[7:0];
            random_table(v);
            run_line(v);
        end
        // Shows the last random line
        run_line(8'd0);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: obj_engine.f
logic/obj_pkg.sv
logic/obj_tbl_if.sv
logic/obj_req_if.sv
logic/obj_tbl_arbiter.sv
logic/obj_scan.sv
logic/obj_draw.sv
logic/obj_linebuf.sv
logic/obj_engine.sv
tests/gfx_rom_model.sv
tests/obj_engine_tb.sv

// File: Bender.yml
package:
  name: obj_engine

sources:
  - logic/obj_pkg.sv
  - logic/obj_tbl_if.sv
  - logic/obj_req_if.sv
  - logic/obj_tbl_arbiter.sv
  - logic/obj_scan.sv
  - logic/obj_draw.sv
  - logic/obj_linebuf.sv
  - logic/obj_engine.sv
  - target: test
    files:
      - tests/gfx_rom_model.sv
      - tests/obj_engine_tb.sv
